/* build.f */
src/multTesterPkg.sv
src/seqMultiplier.sv
src/propertyMonitor.sv
src/wbRegFile.sv
src/multTester.sv
tb/multTester_assert.sv
tb/multTesterTb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run the testbench and search the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module multTesterTb -o multTesterSim \
    && ./obj_dir/multTesterSim | tee /dev/stderr | grep -q "sim passed" \
    && echo "Simulation OK" \
    || { echo "Simulation FAILED"; exit 1; }

exit 0

/* src/multTester.sv */
`timescale 1ns/1ps
// Multiplier tester top level
// Register file, four multiplier units and the property monitor

module multTester import multTesterPkg::*; #(
    parameter int WIDTH        = 16,
    parameter bit constantTime = 1'b0
) (
    input  logic clk,
    input  logic rstN,
    input  wbReq bus,
    output wbRsp rsp
);

    logic               start;
    monFlags            flags;
    logic [WIDTH-1:0]   multiplierOne;
    logic [WIDTH-1:0]   multiplierTwo;
    logic [WIDTH-1:0]   multiplierThree;
    logic [WIDTH-1:0]   multiplierFour;
    logic [WIDTH-1:0]   multiplicandOne;
    logic [WIDTH-1:0]   multiplicandTwo;
    logic [WIDTH-1:0]   multiplicandThree;
    logic [WIDTH-1:0]   multiplicandFour;
    logic [2*WIDTH-1:0] productOne;
    logic [2*WIDTH-1:0] productTwo;
    logic [2*WIDTH-1:0] productThree;
    logic [2*WIDTH-1:0] productFour;
    logic               doneOne;
    logic               doneTwo;
    logic               doneThree;
    logic               doneFour;

    wbRegFile #(.WIDTH(WIDTH)) regFile (
        .clk(clk), .rstN(rstN), .bus(bus), .flags(flags),
        .productOne(productOne), .productTwo(productTwo),
        .productThree(productThree), .productFour(productFour),
        .rsp(rsp), .start(start),
        .multiplierOne(multiplierOne), .multiplierTwo(multiplierTwo),
        .multiplierThree(multiplierThree), .multiplierFour(multiplierFour),
        .multiplicandOne(multiplicandOne), .multiplicandTwo(multiplicandTwo),
        .multiplicandThree(multiplicandThree), .multiplicandFour(multiplicandFour)
    );

    // ========================================
    // Units one and two share the public input
    // ========================================
    seqMultiplier #(.WIDTH(WIDTH), .constantTime(constantTime)) multOne (
        .clk(clk), .rstN(rstN), .start(start), .multiplier(multiplierOne),
        .multiplicand(multiplicandOne), .product(productOne), .done(doneOne)
    );

    seqMultiplier #(.WIDTH(WIDTH), .constantTime(constantTime)) multTwo (
        .clk(clk), .rstN(rstN), .start(start), .multiplier(multiplierTwo),
        .multiplicand(multiplicandTwo), .product(productTwo), .done(doneTwo)
    );

    // Three and four get swapped operands
    seqMultiplier #(.WIDTH(WIDTH), .constantTime(constantTime)) multThree (
        .clk(clk), .rstN(rstN), .start(start), .multiplier(multiplierThree),
        .multiplicand(multiplicandThree), .product(productThree), .done(doneThree)
    );

    seqMultiplier #(.WIDTH(WIDTH), .constantTime(constantTime)) multFour (
        .clk(clk), .rstN(rstN), .start(start), .multiplier(multiplierFour),
        .multiplicand(multiplicandFour), .product(productFour), .done(doneFour)
    );

    propertyMonitor #(.WIDTH(WIDTH)) monitor (
        .clk(clk), .rstN(rstN), .start(start),
        .doneOne(doneOne), .doneTwo(doneTwo), .doneThree(doneThree), .doneFour(doneFour),
        .productThree(productThree), .productFour(productFour), .flags(flags)
    );

endmodule

/* src/multTesterPkg.sv */
// Multiplier tester shared definitions
// Bus widths, register map, Wishbone structs and the status word

package multTesterPkg;

    localparam int busWidth  = 32;
    localparam int addrWidth = 4;

    // ========================================
    // Register map in word addresses
    // ========================================
    typedef enum logic [addrWidth-1:0] {
        regMultiplierOne    = 4'd0,
        regMultiplicandOne  = 4'd1,
        regMultiplierTwo    = 4'd2,
        regMultiplicandTwo  = 4'd3,
        regMultiplierThree  = 4'd4,
        regMultiplicandThree = 4'd5,
        regMultiplierFour   = 4'd6,
        regMultiplicandFour = 4'd7,
        regControl          = 4'd8,   // Bit 0 requests start
        regStatus           = 4'd9,
        regProductOne       = 4'd10,
        regProductTwo       = 4'd11,
        regProductThree     = 4'd12,
        regProductFour      = 4'd13
    } regAddr;

    // ========================================
    // Wishbone classic bus
    // ========================================
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [addrWidth-1:0] adr;
        logic [3:0]           sel;   // Byte lanes
        logic [busWidth-1:0]  dat;
    } wbReq;

    typedef struct packed {
        logic                ack;
        logic [busWidth-1:0] dat;
    } wbRsp;

    // Monitor flags with busy in bit 0
    typedef struct packed {
        logic [27:0] reserved;   // Always zero
        logic        commuteFail;
        logic        timingLeak;
        logic        allDone;
        logic        busy;
    } monFlags;

    typedef union packed {
        logic [busWidth-1:0] raw;   // As seen on the bus
        monFlags             mon;
    } statusWord;

endpackage

/* src/propertyMonitor.sv */
`timescale 1ns/1ps
// Property monitor for the four multiplier units
// Flags timing leakage between units one and two and commutativity of three and four

module propertyMonitor import multTesterPkg::*; #(
    parameter int WIDTH = 16
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  logic               doneOne,
    input  logic               doneTwo,
    input  logic               doneThree,
    input  logic               doneFour,
    input  logic [2*WIDTH-1:0] productThree,
    input  logic [2*WIDTH-1:0] productFour,
    output monFlags            flags
);

    logic [3:0] doneVec;
    logic [3:0] doneSeen;   // Sticky per unit completion
    logic [3:0] seenNext;
    logic       busyQ;
    logic       allDoneQ;
    logic       leakQ;
    logic       commuteQ;

    assign doneVec  = {doneFour, doneThree, doneTwo, doneOne};
    assign seenNext = doneSeen | doneVec;

    // ========================================
    // Run tracking
    // ========================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            busyQ    <= 1'b0;
            allDoneQ <= 1'b0;
            leakQ    <= 1'b0;
            commuteQ <= 1'b0;
            doneSeen <= '0;
        end else if (start) begin
            busyQ    <= 1'b1;   // New run clears the old verdict
            allDoneQ <= 1'b0;
            leakQ    <= 1'b0;
            commuteQ <= 1'b0;
            doneSeen <= '0;
        end else if (busyQ) begin
            doneSeen <= seenNext;

            // Same public input, so any cycle where only one finishes is a leak
            if (doneOne != doneTwo) begin
                leakQ <= 1'b1;
            end

            if (&seenNext) begin
                busyQ    <= 1'b0;
                allDoneQ <= 1'b1;
                commuteQ <= (productThree != productFour);   // Both products valid here
            end
        end
    end

    always_comb begin
        flags             = '0;
        flags.busy        = busyQ;
        flags.allDone     = allDoneQ;
        flags.timingLeak  = leakQ;
        flags.commuteFail = commuteQ;
    end

endmodule

/* src/seqMultiplier.sv */
`timescale 1ns/1ps
// Iterative shift-add multiplier, one multiplier bit per cycle
// Without constantTime it stops once the remaining multiplier bits are zero

module seqMultiplier #(
    parameter int WIDTH        = 16,
    parameter bit constantTime = 1'b0
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  logic [WIDTH-1:0]   multiplier,
    input  logic [WIDTH-1:0]   multiplicand,
    output logic [2*WIDTH-1:0] product,
    output logic               done
);

    localparam int cntWidth = $clog2(WIDTH + 1);
    localparam logic [cntWidth-1:0] lastCount = cntWidth'(WIDTH);

    logic                running;
    logic [cntWidth-1:0] stepCnt;
    logic [2*WIDTH-1:0]  acc;      // Partial product
    logic [2*WIDTH-1:0]  mcand;    // Multiplicand shifted to current weight
    logic [WIDTH-1:0]    mplier;   // Remaining multiplier bits

    logic                load;
    logic                advance;
    logic                finish;
    logic [2*WIDTH-1:0]  srcAcc;
    logic [2*WIDTH-1:0]  srcMcand;
    logic [WIDTH-1:0]    srcMplier;
    logic [cntWidth-1:0] srcCnt;
    logic [2*WIDTH-1:0]  nextAcc;
    logic [2*WIDTH-1:0]  nextMcand;
    logic [WIDTH-1:0]    nextMplier;
    logic [cntWidth-1:0] nextCnt;

    // ========================================
    // One step, fed from the ports on start
    // ========================================
    assign load    = start && !running;   // Start while running is ignored
    assign advance = load || running;

    assign srcAcc    = load ? '0 : acc;
    assign srcMcand  = load ? (2*WIDTH)'(multiplicand) : mcand;
    assign srcMplier = load ? multiplier : mplier;
    assign srcCnt    = load ? '0 : stepCnt;

    assign nextAcc    = srcMplier[0] ? srcAcc + srcMcand : srcAcc;
    assign nextMcand  = srcMcand << 1;
    assign nextMplier = srcMplier >> 1;
    assign nextCnt    = srcCnt + 1'b1;

    // Early exit is what makes latency data dependent
    assign finish = (nextCnt == lastCount) || (!constantTime && nextMplier == '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            running <= 1'b0;
            done    <= 1'b0;
            stepCnt <= '0;
        end else begin
            done <= advance && finish;   // Single cycle pulse
            if (advance) begin
                running <= !finish;
                stepCnt <= nextCnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            acc    <= nextAcc;
            mcand  <= nextMcand;
            mplier <= nextMplier;
        end
    end

    assign product = acc;   // Held until the next start

endmodule

/* src/wbRegFile.sv */
`timescale 1ns/1ps
// Wishbone classic slave register file for the multiplier tester
// Holds operands, issues the start pulse and returns status and products

module wbRegFile import multTesterPkg::*; #(
    parameter int WIDTH = 16
) (
    input  logic               clk,
    input  logic               rstN,
    input  wbReq               bus,
    input  monFlags            flags,
    input  logic [2*WIDTH-1:0] productOne,
    input  logic [2*WIDTH-1:0] productTwo,
    input  logic [2*WIDTH-1:0] productThree,
    input  logic [2*WIDTH-1:0] productFour,
    output wbRsp               rsp,
    output logic               start,
    output logic [WIDTH-1:0]   multiplierOne,
    output logic [WIDTH-1:0]   multiplierTwo,
    output logic [WIDTH-1:0]   multiplierThree,
    output logic [WIDTH-1:0]   multiplierFour,
    output logic [WIDTH-1:0]   multiplicandOne,
    output logic [WIDTH-1:0]   multiplicandTwo,
    output logic [WIDTH-1:0]   multiplicandThree,
    output logic [WIDTH-1:0]   multiplicandFour
);

    logic [WIDTH-1:0]    opReg [8];   // Operands at addresses 0 to 7 in map order
    statusWord           status;
    logic                ackQ;
    logic [busWidth-1:0] datQ;
    logic                take;        // Request seen, ack next cycle
    logic                wrEn;        // Write committed at end of ack cycle
    logic                opWrEn;
    logic                startReq;
    logic [busWidth-1:0] rdData;
    logic [busWidth-1:0] wrMerged;

    assign status.mon = flags;

    // ========================================
    // Bus handshake
    // ========================================
    assign take   = bus.cyc && bus.stb && !ackQ;   // Drops ack even if stb stays up
    assign wrEn   = ackQ && bus.cyc && bus.stb && bus.we;
    assign opWrEn = wrEn && !bus.adr[3] && !status.mon.busy;   // Still acked when busy

    assign startReq = wrEn && (regAddr'(bus.adr) == regControl) && bus.sel[0]
                      && bus.dat[0] && !status.mon.busy && !start;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ackQ  <= 1'b0;
            start <= 1'b0;
        end else begin
            ackQ  <= take;
            start <= startReq;   // Lands the cycle after the ack
        end
    end

    assign rsp.ack = ackQ;
    assign rsp.dat = datQ;

    // Byte lane merge into the addressed operand
    always_comb begin
        wrMerged = busWidth'(opReg[bus.adr[2:0]]);
        for (int b = 0; b < busWidth / 8; b++) begin
            if (bus.sel[b]) begin
                wrMerged[8*b +: 8] = bus.dat[8*b +: 8];
            end
        end
    end

    // ========================================
    // Read mux
    // ========================================
    always_comb begin
        rdData = '0;   // Control and unmapped read as zero
        case (regAddr'(bus.adr))
            regStatus:       rdData = status.raw;
            regProductOne:   rdData = busWidth'(productOne);
            regProductTwo:   rdData = busWidth'(productTwo);
            regProductThree: rdData = busWidth'(productThree);
            regProductFour:  rdData = busWidth'(productFour);
            default: begin
                if (!bus.adr[3]) begin
                    rdData = busWidth'(opReg[bus.adr[2:0]]);
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (take) begin
            datQ <= rdData;   // Valid while ack is high
        end
        if (opWrEn) begin
            opReg[bus.adr[2:0]] <= wrMerged[WIDTH-1:0];   // Truncated to WIDTH
        end
    end

    assign multiplierOne     = opReg[0];
    assign multiplicandOne   = opReg[1];
    assign multiplierTwo     = opReg[2];
    assign multiplicandTwo   = opReg[3];
    assign multiplierThree   = opReg[4];
    assign multiplicandThree = opReg[5];
    assign multiplierFour    = opReg[6];
    assign multiplicandFour  = opReg[7];

endmodule

/* tb/multTesterTb.sv */
`timescale 1ns/1ps
// Directed testbench for the multiplier tester
// Drives the Wishbone port and checks products and monitor flags

module multTesterTb import multTesterPkg::*; ();

    localparam int WIDTH      = 16;
    localparam int cycleLimit = 4000;   // About 10 runs of 60 cycles plus bus traffic

    logic clk = 1'b0;
    logic rstN;
    wbReq bus;
    wbRsp rsp;

    int               errorCount = 0;
    int               cycleCount = 0;
    int               seed       = 32'h5aa5fad6;
    logic [WIDTH-1:0] mplr [4];   // Operands of the next run by unit
    logic [WIDTH-1:0] mcnd [4];

    multTester #(.WIDTH(WIDTH), .constantTime(1'b0)) dut (
        .clk(clk), .rstN(rstN), .bus(bus), .rsp(rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    // ========================================
    // Bus transfers
    // ========================================
    task automatic wbWrite(input logic [addrWidth-1:0] adr, input logic [busWidth-1:0] data);
        @(posedge clk);
        bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, sel: 4'hF, dat: data};
        do begin
            @(posedge clk);
        end while (!rsp.ack);
        bus <= '0;   // Write commits on this edge
    endtask

    task automatic wbRead(input logic [addrWidth-1:0] adr, output logic [busWidth-1:0] data);
        @(posedge clk);
        bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, sel: 4'hF, dat: '0};
        do begin
            @(posedge clk);
        end while (!rsp.ack);
        data = rsp.dat;
        bus  <= '0;
    endtask

    task automatic checkWord(input string name, input logic [busWidth-1:0] got,
                             input logic [busWidth-1:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkFlags(input string name, input monFlags got, input monFlags exp);
        if (got !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s got busy=%b allDone=%b leak=%b commute=%b",
                     $time, name, got.busy, got.allDone, got.timingLeak, got.commuteFail);
            $display("    expected busy=%b allDone=%b leak=%b commute=%b",
                     exp.busy, exp.allDone, exp.timingLeak, exp.commuteFail);
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    // Cycles from start to done with early termination
    function automatic int latency(input logic [WIDTH-1:0] m);
        int len;
        len = 0;
        for (int b = 0; b < WIDTH; b++) begin
            if (m[b]) begin
                len = b + 1;
            end
        end
        return (len < 1) ? 1 : len;
    endfunction

    function automatic logic [busWidth-1:0] expectedProduct(input int unit);
        return busWidth'(mplr[unit]) * busWidth'(mcnd[unit]);
    endfunction

    function automatic monFlags expectedFlags();
        monFlags f;
        f             = '0;
        f.allDone     = 1'b1;
        f.timingLeak  = latency(mplr[0]) != latency(mplr[1]);
        f.commuteFail = expectedProduct(2) != expectedProduct(3);
        return f;
    endfunction

    task automatic loadAndStart();
        for (int i = 0; i < 4; i++) begin
            wbWrite(addrWidth'(2 * i), busWidth'(mplr[i]));
            wbWrite(addrWidth'(2 * i + 1), busWidth'(mcnd[i]));
        end
        wbWrite(regControl, 32'h1);
    endtask

    // Polls status until the run ends, then checks flags and products
    task automatic finishAndCheck(input string label);
        statusWord           s;
        logic [busWidth-1:0] word;
        s.raw = '0;
        while (!s.mon.allDone) begin
            wbRead(regStatus, s.raw);
        end
        checkFlags($sformatf("%s status", label), s.mon, expectedFlags());
        for (int i = 0; i < 4; i++) begin
            wbRead(addrWidth'(regProductOne + i), word);
            checkWord($sformatf("%s product%0d", label, i + 1), word, expectedProduct(i));
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic resetReadback();
        logic [busWidth-1:0] word;
        wbRead(regStatus, word);
        checkWord("status after reset", word, '0);
        wbWrite(regMultiplierOne, 32'hABCD_1234);
        wbWrite(regMultiplicandFour, 32'h0001_FFFF);
        wbRead(regMultiplierOne, word);
        checkWord("multiplierOne readback", word, 32'h0000_1234);   // Upper half dropped
        wbRead(regMultiplicandFour, word);
        checkWord("multiplicandFour readback", word, 32'h0000_FFFF);
    endtask

    task automatic randomProducts();
        for (int run = 0; run < 3; run++) begin
            for (int i = 0; i < 4; i++) begin
                mplr[i] = WIDTH'($random(seed));
                mcnd[i] = WIDTH'($random(seed));
            end
            loadAndStart();
            finishAndCheck($sformatf("random run %0d", run));
        end
    endtask

    task automatic timingLeakPairs();
        mplr = '{16'h0003, 16'h8001, 16'h1234, 16'h00FF};   // Bit lengths 2 and 16
        mcnd = '{16'h00A5, 16'h00A5, 16'h00FF, 16'h1234};
        loadAndStart();
        finishAndCheck("leak differing length");
        mplr[1] = 16'h0002;   // Same bit length as unit one
        loadAndStart();
        finishAndCheck("leak equal length");
    endtask

    task automatic swappedOperands();
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        a    = WIDTH'($random(seed));
        b    = WIDTH'($random(seed));
        mplr = '{a, a, a, b};
        mcnd = '{b, b, b, a};
        loadAndStart();
        finishAndCheck("commute random");
        mplr = '{16'hFFFF, 16'hFFFF, 16'hFFFF, 16'h0001};
        mcnd = '{16'h0001, 16'h0001, 16'h0001, 16'hFFFF};
        loadAndStart();
        finishAndCheck("commute ones");
    endtask

    task automatic edgeOperands();
        mplr = '{16'h0000, 16'h0001, 16'hFFFF, 16'hFFFF};
        mcnd = '{16'h1234, 16'h1234, 16'hFFFF, 16'hFFFF};
        loadAndStart();
        finishAndCheck("edge zero and ones");
        mplr = '{16'h0001, 16'h0000, 16'h0001, 16'hBEEF};
        mcnd = '{16'hFFFF, 16'hFFFF, 16'hBEEF, 16'h0001};
        loadAndStart();
        finishAndCheck("edge unit multiplier");
    endtask

    task automatic busyProtection();
        statusWord           s;
        monFlags             busyOnly;
        logic [busWidth-1:0] word;
        busyOnly      = '0;
        busyOnly.busy = 1'b1;
        // Leaking run first so the next start has stale flags to clear
        mplr = '{16'h0003, 16'h8001, 16'h0005, 16'h0007};
        mcnd = '{16'h0011, 16'h0011, 16'h0007, 16'h0005};
        loadAndStart();
        finishAndCheck("pre busy");
        mplr = '{16'h8001, 16'hC003, 16'hA5A5, 16'h9999};   // Full length keeps it busy
        mcnd = '{16'h0101, 16'h0101, 16'h9999, 16'hA5A5};
        loadAndStart();
        wbWrite(regMultiplierOne, 32'h0000_0005);   // Dropped while busy
        wbWrite(regControl, 32'h1);
        wbRead(regStatus, s.raw);
        checkFlags("status while busy", s.mon, busyOnly);
        wbRead(regMultiplierOne, word);
        checkWord("multiplierOne kept while busy", word, busWidth'(mplr[0]));
        finishAndCheck("busy protection");
    endtask

    initial begin
        rstN <= 1'b0;
        bus  <= '0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        resetReadback();
        randomProducts();
        timingLeakPairs();
        swappedOperands();
        edgeOperands();
        busyProtection();
        $display("Tests done with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tb/multTester_assert.sv */
`timescale 1ns/1ps
// Bus protocol and monitor flag assertions for the register file

module multTesterAssert import multTesterPkg::*; (
    input logic    clk,
    input logic    rstN,
    input wbRsp    rsp,
    input logic    start,
    input monFlags flags
);

    // ========================================
    // Wishbone handshake
    // ========================================
    ackSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
        rsp.ack |=> !rsp.ack)
        else $error("ack stayed high for two cycles");

    // ========================================
    // Run control
    // ========================================
    startOnlyWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
        $rose(start) |-> !flags.busy)
        else $error("start rose while a run was busy");

    doneExcludesBusy: assert property (@(posedge clk) disable iff (!rstN)
        !(flags.allDone && flags.busy))
        else $error("allDone and busy high together");   // Mutually exclusive states

endmodule

bind wbRegFile multTesterAssert protocolCheck (
    .clk(clk), .rstN(rstN), .rsp(rsp), .start(start), .flags(flags)
);
